/* verilog/mi_pkg.sv */
// widths and codes shared by all blocks; N_CLIENTS is fixed at 2 because the client wiring is fixed
package mi_pkg;

	// --------------------
	// sizes
	localparam int N_CLIENTS     = 2;
	localparam int LINE_OFFSET_W = 6;
	localparam int NPHYS         = 48;
	localparam int LINE_BITS     = 512;
	localparam int TRANS_W       = 6;
	localparam int CLIENT_W      = 1;

	typedef logic [NPHYS-LINE_OFFSET_W-1:0] line_addr_t;
	typedef logic [LINE_BITS-1:0]           line_t;
	typedef logic [TRANS_W-1:0]             trans_t;

	// --------------------
	// cache side request and snoop codes
	typedef enum logic [2:0] {
		RSNOOP_READ_LINE            = 3'd0,
		RSNOOP_READ_LINE_SHARED     = 3'd1,
		RSNOOP_READ_LINE_EXCLUSIVE  = 3'd2,
		RSNOOP_READ_LINE_INV_SHARED = 3'd3,
		RSNOOP_READ_CANCEL          = 3'd4
	} rsnoop_t;

	typedef enum logic [1:0] {
		SNOOP_READ_UNSHARED  = 2'd0,
		SNOOP_READ_SHARED    = 2'd1,
		SNOOP_READ_EXCLUSIVE = 2'd2,
		SNOOP_READ_INVALID   = 2'd3
	} snoop_t;

	typedef logic [2:0] resp_t;

	localparam int    RESP_DATA_INCLUDED = 2;    // bit index, line travels with the resp
	localparam resp_t RESP_MEM           = 3'd1; // plain memory data
	localparam resp_t RESP_INV           = 3'd2;

	// --------------------
	// memory tag, client number above the cache trans id
	typedef struct packed {
		logic [CLIENT_W-1:0] client;
		trans_t              trans;
	} mem_tag_s;

	typedef union packed {
		logic [CLIENT_W+TRANS_W-1:0] raw;
		mem_tag_s                    f;
	} mem_tag_u;

endpackage

/* verilog/mi_ifs.sv */
// req is a level held until done or grant; done is a single cycle pulse, resp and data valid with it
`timescale 1ns/1ps

// read or write port to the snoop arbiter
interface snoop_req_if import mi_pkg::*; ();
	logic       req;
	line_addr_t addr;
	snoop_t     kind;
	logic       done;
	resp_t      resp;
	line_t      data;

	modport initiator (
		output req, addr, kind,
		input  done, resp, data
	);

	modport target (
		input  req, addr, kind,
		output done, resp, data
	);
endinterface

// read port to the memory read mux, request side and return side
interface mem_rd_if import mi_pkg::*; ();
	logic       req;
	line_addr_t addr;
	trans_t     trans;
	logic       grant;
	logic       rvalid;
	line_t      rdata;
	trans_t     rtrans;
	logic       rready;

	modport client (
		output req, addr, trans, rready,
		input  grant, rvalid, rdata, rtrans
	);

	modport mux (
		input  req, addr, trans, rready,
		output grant, rvalid, rdata, rtrans
	);
endinterface

/* verilog/snoop_arbiter.sv */
// one snoop in flight at a time; ic0 never supplies line data so its data bit is dropped
`timescale 1ns/1ps

module snoop_arbiter import mi_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	snoop_req_if.target rq [3],	// 0 ic0 read, 1 dc0 read, 2 dc0 write
	output logic        ic0_snoop_addr_req,
	output logic        dc0_snoop_addr_req,
	output line_addr_t  snoop_addr,
	output snoop_t      snoop_snoop,
	input  logic        ic0_snoop_addr_ack,
	input  logic        dc0_snoop_addr_ack,
	input  resp_t       ic0_snoop_data_resp,
	input  resp_t       dc0_snoop_data_resp,
	input  line_t       dc0_snoop_data
);

	logic [2:0] req_v;
	line_addr_t addr_v [3];
	snoop_t     kind_v [3];
	logic [2:0] done_v;
	resp_t      resp_x;
	logic [1:0] cur;	// requester being served
	logic [1:0] last;	// round robin position
	logic [1:0] pick;
	logic       pick_ok;
	logic       resp_phase;	// cycle after the ack, cache resp is on its inputs
	logic       idle;
	logic       ack;

	for (genvar g = 0; g < 3; g++) begin : g_rq
		assign req_v[g]   = rq[g].req;
		assign addr_v[g]  = rq[g].addr;
		assign kind_v[g]  = rq[g].kind;
		assign done_v[g]  = resp_phase && cur == 2'(g);
		assign rq[g].done = done_v[g];
		assign rq[g].resp = resp_x;
		assign rq[g].data = dc0_snoop_data;	// only dc0 can hold a line
	end

	assign idle = !ic0_snoop_addr_req && !dc0_snoop_addr_req && !resp_phase;
	assign ack  = (ic0_snoop_addr_req && ic0_snoop_addr_ack) ||
		(dc0_snoop_addr_req && dc0_snoop_addr_ack);

	// next requester after the last one served
	always_comb begin
		logic [1:0] idx;
		pick    = last;
		pick_ok = 1'b0;
		for (int k = 1; k <= 3; k++) begin
			idx = 2'((int'(last) + k) % 3);
			if (!pick_ok && req_v[idx]) begin
				pick    = idx;
				pick_ok = 1'b1;
			end
		end
	end

	always_comb begin
		resp_x = (cur == 2'd0) ? dc0_snoop_data_resp : ic0_snoop_data_resp;
		if (cur != 2'd0)
			resp_x[RESP_DATA_INCLUDED] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ic0_snoop_addr_req <= 1'b0;
			dc0_snoop_addr_req <= 1'b0;
			resp_phase         <= 1'b0;
			cur                <= 2'd0;
			last               <= 2'd2;	// ic0 read first
		end else begin
			resp_phase <= 1'b0;
			if (idle && pick_ok) begin
				cur                <= pick;
				last               <= pick;
				dc0_snoop_addr_req <= pick == 2'd0;	// ic0 read looks in dc0
				ic0_snoop_addr_req <= pick != 2'd0;	// dc0 read and write look in ic0
			end else if (ack) begin
				ic0_snoop_addr_req <= 1'b0;
				dc0_snoop_addr_req <= 1'b0;
				resp_phase         <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (idle && pick_ok) begin
			snoop_addr  <= addr_v[pick];
			snoop_snoop <= kind_v[pick];
		end
	end

	// both caches share the snoop address bus
	a_one_target: assert property (@(posedge clk) disable iff (reset)
		!(ic0_snoop_addr_req && dc0_snoop_addr_req));

	// requester keeps req up until its done
	a_done_req: assert property (@(posedge clk) disable iff (reset)
		(done_v & ~req_v) == 3'b000);

endmodule

/* verilog/client_read_port.sv */
// one read in flight per cache; a cancel is accepted and ignored, it never returns data
`timescale 1ns/1ps

module client_read_port import mi_pkg::*; #(
	parameter int CLIENT_ID = 0
) (
	input  logic           clk,
	input  logic           reset,
	input  line_addr_t     raddr,
	input  logic           raddr_req,
	output logic           raddr_ack,
	input  trans_t         raddr_trans,
	input  rsnoop_t        raddr_snoop,
	output line_t          rdata,
	output logic           rdata_req,
	input  logic           rdata_ack,
	output trans_t         rdata_trans,
	output resp_t          rdata_resp,
	snoop_req_if.initiator sn,
	mem_rd_if.client       mr
);

	logic       busy;	// accepted and not yet taken by the cache
	logic       snoop_pend;
	logic       mem_req;
	logic       mem_wait;	// granted, line not back yet
	logic       accept;
	logic       snoop_hit;
	logic       mem_ret;
	line_addr_t addr_q;
	trans_t     trans_q;
	snoop_t     kind_q;

	function automatic snoop_t snoop_kind(input rsnoop_t k);
		case (k)
		RSNOOP_READ_LINE_SHARED:     return SNOOP_READ_SHARED;
		RSNOOP_READ_LINE_EXCLUSIVE:  return SNOOP_READ_EXCLUSIVE;
		RSNOOP_READ_LINE_INV_SHARED: return SNOOP_READ_INVALID;
		default:                     return SNOOP_READ_UNSHARED;
		endcase
	endfunction

	assign raddr_ack = !busy;
	assign accept    = raddr_req && raddr_ack && raddr_snoop != RSNOOP_READ_CANCEL;

	// inv-shared never goes to memory
	assign snoop_hit = kind_q == SNOOP_READ_INVALID || sn.resp[RESP_DATA_INCLUDED];
	assign mem_ret   = mr.rvalid && mr.rready;

	assign sn.req    = snoop_pend;
	assign sn.addr   = addr_q;
	assign sn.kind   = kind_q;
	assign mr.req    = mem_req;
	assign mr.addr   = addr_q;
	assign mr.trans  = trans_q;
	assign mr.rready = mem_wait;

	// --------------------
	// sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			snoop_pend <= 1'b0;
			mem_req    <= 1'b0;
			mem_wait   <= 1'b0;
			rdata_req  <= 1'b0;
		end else begin
			if (accept) begin
				busy       <= 1'b1;
				snoop_pend <= 1'b1;
			end
			if (sn.done) begin
				snoop_pend <= 1'b0;
				if (snoop_hit)
					rdata_req <= 1'b1;
				else
					mem_req <= 1'b1;	// fall back to memory
			end
			if (mr.req && mr.grant) begin
				mem_req  <= 1'b0;
				mem_wait <= 1'b1;
			end
			if (mem_ret) begin
				mem_wait  <= 1'b0;
				rdata_req <= 1'b1;
			end
			if (rdata_req && rdata_ack) begin
				rdata_req <= 1'b0;
				busy      <= 1'b0;
			end
		end
	end

	// --------------------
	// request and return payload
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= raddr;
			trans_q <= raddr_trans;
			kind_q  <= snoop_kind(raddr_snoop);
		end
		if (sn.done && snoop_hit) begin
			rdata       <= sn.data;
			rdata_resp  <= (kind_q == SNOOP_READ_INVALID) ? RESP_INV : sn.resp;
			rdata_trans <= trans_q;
		end
		if (mem_ret) begin
			rdata       <= mr.rdata;
			rdata_resp  <= RESP_MEM;
			rdata_trans <= mr.rtrans;	// tag comes back from memory
		end
	end

	// memory must only return a line this port asked for
	a_rvalid_expected: assert property (@(posedge clk) disable iff (reset)
		mr.rvalid |-> mem_wait)
		else $error("client %0d: memory line with no read outstanding", CLIENT_ID);

endmodule

/* verilog/line_writeback.sv */
// dc0 only, one writeback at a time; the ic0 invalidate and memory write go out together
`timescale 1ns/1ps

module line_writeback import mi_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  line_addr_t     waddr,
	input  logic           waddr_req,
	output logic           waddr_ack,
	input  trans_t         waddr_trans,
	input  line_t          wdata,
	output trans_t         wdata_trans,
	output logic           wdata_done,
	snoop_req_if.initiator sn,
	output line_addr_t     mem_waddr,
	output line_t          mem_wdata,
	output mem_tag_u       mem_waddr_trans,
	output logic           mem_waddr_req,
	input  logic           mem_waddr_ack,
	input  mem_tag_u       mem_wdata_trans,
	input  logic           mem_wdata_done
);

	logic       snoop_pend;
	logic       mem_pend;
	logic       accept;
	line_addr_t addr_q;
	trans_t     trans_q;
	line_t      data_q;

	assign waddr_ack = !snoop_pend && !mem_pend;	// both halves finished
	assign accept    = waddr_req && waddr_ack;

	assign sn.req  = snoop_pend;
	assign sn.addr = addr_q;
	assign sn.kind = SNOOP_READ_INVALID;	// drop any ic0 copy

	assign mem_waddr_req = mem_pend;
	assign mem_waddr     = addr_q;
	assign mem_wdata     = data_q;

	always_comb begin
		mem_waddr_trans.f.client = 1'b1;	// dc0
		mem_waddr_trans.f.trans  = trans_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			snoop_pend <= 1'b0;
			mem_pend   <= 1'b0;
			wdata_done <= 1'b0;
		end else begin
			if (accept) begin
				snoop_pend <= 1'b1;
				mem_pend   <= 1'b1;
			end
			if (sn.done)
				snoop_pend <= 1'b0;
			if (mem_waddr_req && mem_waddr_ack)
				mem_pend <= 1'b0;
			wdata_done <= mem_wdata_done && mem_wdata_trans.f.client == 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= waddr;
			trans_q <= waddr_trans;
			data_q  <= wdata;
		end
		if (mem_wdata_done)
			wdata_trans <= mem_wdata_trans.f.trans;
	end

endmodule

/* verilog/mem_read_mux.sv */
// request path and return routing are combinational; memory holds a line until its client is ready
`timescale 1ns/1ps

module mem_read_mux import mi_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	mem_rd_if.mux        mr [N_CLIENTS],
	output line_addr_t   mem_raddr,
	output logic         mem_raddr_req,
	output mem_tag_u     mem_raddr_trans,
	input  logic         mem_raddr_ack,
	input  line_t        mem_rdata,
	input  mem_tag_u     mem_rdata_trans,
	input  logic         mem_rdata_req,
	output logic         mem_rdata_ack
);

	logic [N_CLIENTS-1:0] req_v;
	logic [N_CLIENTS-1:0] grant_v;
	logic [N_CLIENTS-1:0] rready_v;
	line_addr_t           addr_v [N_CLIENTS];
	trans_t               trans_v [N_CLIENTS];
	logic [CLIENT_W-1:0]  ptr;	// first client to look at
	logic [CLIENT_W-1:0]  sel;
	logic [CLIENT_W-1:0]  ret_client;
	logic                 any;

	assign ret_client = mem_rdata_trans.f.client;

	for (genvar g = 0; g < N_CLIENTS; g++) begin : g_mr
		assign req_v[g]     = mr[g].req;
		assign addr_v[g]    = mr[g].addr;
		assign trans_v[g]   = mr[g].trans;
		assign rready_v[g]  = mr[g].rready;
		assign grant_v[g]   = mem_raddr_ack && any && sel == CLIENT_W'(g);
		assign mr[g].grant  = grant_v[g];
		assign mr[g].rvalid = mem_rdata_req && ret_client == CLIENT_W'(g);
		assign mr[g].rdata  = mem_rdata;
		assign mr[g].rtrans = mem_rdata_trans.f.trans;
	end

	// --------------------
	// request side
	always_comb begin
		logic [CLIENT_W-1:0] idx;
		sel = ptr;
		any = 1'b0;
		for (int k = 0; k < N_CLIENTS; k++) begin
			idx = CLIENT_W'((int'(ptr) + k) % N_CLIENTS);
			if (!any && req_v[idx]) begin
				sel = idx;
				any = 1'b1;
			end
		end
	end

	assign mem_raddr_req = any;
	assign mem_raddr     = addr_v[sel];

	always_comb begin
		mem_raddr_trans.f.client = sel;
		mem_raddr_trans.f.trans  = trans_v[sel];
	end

	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '0;
		else if (mem_raddr_req && mem_raddr_ack)
			ptr <= CLIENT_W'((int'(sel) + 1) % N_CLIENTS);	// served client goes last
	end

	// --------------------
	// return side, back-pressure straight from the tagged client
	assign mem_rdata_ack = rready_v[ret_client];

	// memory echoes only tags this mux built
	a_tag_client: assert property (@(posedge clk) disable iff (reset)
		mem_rdata_req |-> int'(mem_rdata_trans.raw >> TRANS_W) < N_CLIENTS);

endmodule

/* verilog/mem_interconnect.sv */
// ic0 read only, dc0 read and write; one read per cache in flight, no read merging, cancels return nothing
`timescale 1ns/1ps

module mem_interconnect import mi_pkg::*; (
	input  logic       clk,
	input  logic       reset,

	// ic0
	input  line_addr_t ic0_raddr,
	input  logic       ic0_raddr_req,
	output logic       ic0_raddr_ack,
	input  trans_t     ic0_raddr_trans,
	input  rsnoop_t    ic0_raddr_snoop,
	output line_t      ic0_rdata,
	output logic       ic0_rdata_req,
	input  logic       ic0_rdata_ack,
	output trans_t     ic0_rdata_trans,
	output resp_t      ic0_rdata_resp,
	output line_addr_t ic0_snoop_addr,
	output logic       ic0_snoop_addr_req,
	input  logic       ic0_snoop_addr_ack,
	output snoop_t     ic0_snoop_snoop,
	input  resp_t      ic0_snoop_data_resp,	// cycle after the ack

	// dc0
	input  line_addr_t dc0_raddr,
	input  logic       dc0_raddr_req,
	output logic       dc0_raddr_ack,
	input  trans_t     dc0_raddr_trans,
	input  rsnoop_t    dc0_raddr_snoop,
	output line_t      dc0_rdata,
	output logic       dc0_rdata_req,
	input  logic       dc0_rdata_ack,
	output trans_t     dc0_rdata_trans,
	output resp_t      dc0_rdata_resp,
	input  line_addr_t dc0_waddr,
	input  logic       dc0_waddr_req,
	output logic       dc0_waddr_ack,
	input  trans_t     dc0_waddr_trans,
	input  line_t      dc0_wdata,
	output trans_t     dc0_wdata_trans,
	output logic       dc0_wdata_done,
	output line_addr_t dc0_snoop_addr,
	output logic       dc0_snoop_addr_req,
	input  logic       dc0_snoop_addr_ack,
	output snoop_t     dc0_snoop_snoop,
	input  resp_t      dc0_snoop_data_resp,	// cycle after the ack
	input  line_t      dc0_snoop_data,

	// memory
	output line_addr_t mem_raddr,
	output logic       mem_raddr_req,
	output mem_tag_u   mem_raddr_trans,
	input  logic       mem_raddr_ack,
	input  line_t      mem_rdata,
	input  mem_tag_u   mem_rdata_trans,
	output logic       mem_rdata_ack,
	input  logic       mem_rdata_req,
	output line_addr_t mem_waddr,
	output line_t      mem_wdata,
	output mem_tag_u   mem_waddr_trans,
	output logic       mem_waddr_req,
	input  logic       mem_waddr_ack,
	input  mem_tag_u   mem_wdata_trans,
	input  logic       mem_wdata_done
);

	snoop_req_if snp [3] ();	// ic0 read, dc0 read, dc0 write
	mem_rd_if    mrd [N_CLIENTS] ();

	line_addr_t snoop_addr;
	snoop_t     snoop_snoop;

	// one snoop bus seen by both caches
	assign ic0_snoop_addr  = snoop_addr;
	assign dc0_snoop_addr  = snoop_addr;
	assign ic0_snoop_snoop = snoop_snoop;
	assign dc0_snoop_snoop = snoop_snoop;

	client_read_port #(.CLIENT_ID(0)) u_ic0_rd (
		.clk(clk), .reset(reset),
		.raddr(ic0_raddr), .raddr_req(ic0_raddr_req), .raddr_ack(ic0_raddr_ack),
		.raddr_trans(ic0_raddr_trans), .raddr_snoop(ic0_raddr_snoop),
		.rdata(ic0_rdata), .rdata_req(ic0_rdata_req), .rdata_ack(ic0_rdata_ack),
		.rdata_trans(ic0_rdata_trans), .rdata_resp(ic0_rdata_resp),
		.sn(snp[0]), .mr(mrd[0])
	);

	client_read_port #(.CLIENT_ID(1)) u_dc0_rd (
		.clk(clk), .reset(reset),
		.raddr(dc0_raddr), .raddr_req(dc0_raddr_req), .raddr_ack(dc0_raddr_ack),
		.raddr_trans(dc0_raddr_trans), .raddr_snoop(dc0_raddr_snoop),
		.rdata(dc0_rdata), .rdata_req(dc0_rdata_req), .rdata_ack(dc0_rdata_ack),
		.rdata_trans(dc0_rdata_trans), .rdata_resp(dc0_rdata_resp),
		.sn(snp[1]), .mr(mrd[1])
	);

	line_writeback u_dc0_wb (
		.clk(clk), .reset(reset),
		.waddr(dc0_waddr), .waddr_req(dc0_waddr_req), .waddr_ack(dc0_waddr_ack),
		.waddr_trans(dc0_waddr_trans), .wdata(dc0_wdata),
		.wdata_trans(dc0_wdata_trans), .wdata_done(dc0_wdata_done),
		.sn(snp[2]),
		.mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_waddr_trans(mem_waddr_trans),
		.mem_waddr_req(mem_waddr_req), .mem_waddr_ack(mem_waddr_ack),
		.mem_wdata_trans(mem_wdata_trans), .mem_wdata_done(mem_wdata_done)
	);

	snoop_arbiter u_snoop (
		.clk(clk), .reset(reset),
		.rq(snp),
		.ic0_snoop_addr_req(ic0_snoop_addr_req), .dc0_snoop_addr_req(dc0_snoop_addr_req),
		.snoop_addr(snoop_addr), .snoop_snoop(snoop_snoop),
		.ic0_snoop_addr_ack(ic0_snoop_addr_ack), .dc0_snoop_addr_ack(dc0_snoop_addr_ack),
		.ic0_snoop_data_resp(ic0_snoop_data_resp), .dc0_snoop_data_resp(dc0_snoop_data_resp),
		.dc0_snoop_data(dc0_snoop_data)
	);

	mem_read_mux u_mem_rd (
		.clk(clk), .reset(reset),
		.mr(mrd),
		.mem_raddr(mem_raddr), .mem_raddr_req(mem_raddr_req),
		.mem_raddr_trans(mem_raddr_trans), .mem_raddr_ack(mem_raddr_ack),
		.mem_rdata(mem_rdata), .mem_rdata_trans(mem_rdata_trans),
		.mem_rdata_req(mem_rdata_req), .mem_rdata_ack(mem_rdata_ack)
	);

endmodule

/* dv/tb_mem_interconnect.sv */
// cache and memory models answer after random delays; one writeback is checked at a time
`timescale 1ns/1ps

module tb_mem_interconnect import mi_pkg::*; ();

	localparam int    N_RAND      = 16;	// reads per cache in the overlap test
	localparam int    N_OPS       = 4 + 2 * N_RAND;
	localparam resp_t DC_HIT_RESP = 3'b101;	// data included, shared

	logic       clk = 1'b0;
	logic       reset;
	line_addr_t ic0_raddr, dc0_raddr, dc0_waddr, ic0_snoop_addr, dc0_snoop_addr;
	line_addr_t mem_raddr, mem_waddr;
	logic       ic0_raddr_req, ic0_raddr_ack, ic0_rdata_req, ic0_rdata_ack;
	logic       dc0_raddr_req, dc0_raddr_ack, dc0_rdata_req, dc0_rdata_ack;
	logic       dc0_waddr_req, dc0_waddr_ack, dc0_wdata_done;
	logic       ic0_snoop_addr_req, ic0_snoop_addr_ack, dc0_snoop_addr_req, dc0_snoop_addr_ack;
	logic       mem_raddr_req, mem_raddr_ack, mem_rdata_req, mem_rdata_ack;
	logic       mem_waddr_req, mem_waddr_ack, mem_wdata_done;
	trans_t     ic0_raddr_trans, ic0_rdata_trans, dc0_raddr_trans, dc0_rdata_trans;
	trans_t     dc0_waddr_trans, dc0_wdata_trans;
	rsnoop_t    ic0_raddr_snoop, dc0_raddr_snoop;
	snoop_t     ic0_snoop_snoop, dc0_snoop_snoop;
	resp_t      ic0_rdata_resp, dc0_rdata_resp, ic0_snoop_data_resp, dc0_snoop_data_resp;
	line_t      ic0_rdata, dc0_rdata, dc0_wdata, dc0_snoop_data, mem_rdata, mem_wdata;
	mem_tag_u   mem_raddr_trans, mem_rdata_trans, mem_waddr_trans, mem_wdata_trans;

	integer     seed;
	string      test_name;
	logic       pending [N_CLIENTS];	// read accepted, data not yet taken
	logic       exp_mem [N_CLIENTS];
	resp_t      exp_resp [N_CLIENTS];
	line_t      exp_line [N_CLIENTS];
	line_addr_t exp_addr [N_CLIENTS];
	trans_t     exp_trans [N_CLIENTS];
	snoop_t     exp_snoop [N_CLIENTS];
	int         n_issued, n_cancels, n_rdata;
	line_addr_t wr_addr, ic_snp_addr, dc_snp_addr;
	line_t      wr_data;
	trans_t     wr_trans;
	logic       wr_mem_pend, wr_done_pend;
	snoop_t     ic_snp_kind;
	line_addr_t rd_q_addr [$];	// memory reads not yet returned
	mem_tag_u   rd_q_tag [$];

	mem_interconnect u_dut (.*);

	always #50 clk = ~clk;

	// --------------------
	// reference
	function automatic line_t line_of_mem(input line_addr_t a);
		line_t l;
		for (int i = 0; i < 8; i++)
			l[i*64 +: 64] = {6'(i), 16'ha5c3, a};
		return l;
	endfunction

	function automatic line_t line_of_dc(input line_addr_t a);
		line_t l;
		for (int i = 0; i < 8; i++)
			l[i*64 +: 64] = {6'(i), 16'h3c5a, ~a};
		return l;
	endfunction

	// returns 1 when the read has to go to memory
	function automatic logic expected_read(input int c, input rsnoop_t k, input line_addr_t a,
		output resp_t r, output line_t l);
		logic dc_owns;
		dc_owns = c == 0 && a[0];	// only ic0 reads look in dc0
		if (k == RSNOOP_READ_LINE_INV_SHARED) begin
			r = RESP_INV;
			l = dc_owns ? line_of_dc(a) : '0;
			return 1'b0;
		end
		if (dc_owns) begin
			r = DC_HIT_RESP;
			l = line_of_dc(a);
			return 1'b0;
		end
		r = RESP_MEM;
		l = line_of_mem(a);
		return 1'b1;
	endfunction

	// snoop kind the other cache sees for a read
	function automatic snoop_t snoop_for_read(input rsnoop_t k);
		case (k)
		RSNOOP_READ_LINE:            return SNOOP_READ_UNSHARED;
		RSNOOP_READ_LINE_SHARED:     return SNOOP_READ_SHARED;
		RSNOOP_READ_LINE_EXCLUSIVE:  return SNOOP_READ_EXCLUSIVE;
		RSNOOP_READ_LINE_INV_SHARED: return SNOOP_READ_INVALID;
		default:                     return SNOOP_READ_UNSHARED;
		endcase
	endfunction

	function automatic logic coin(input int n);
		return ($unsigned($random(seed)) % 32'(n)) == 0;
	endfunction

	// --------------------
	// checks
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_resp(input string what, input resp_t e, input resp_t a);
		if (a !== e)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what, e, a));
	endtask

	task automatic check_line(input string what, input line_t e, input line_t a);
		if (a !== e)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what, e, a));
	endtask

	task automatic check_trans(input string what, input trans_t e, input trans_t a);
		if (a !== e)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what, e, a));
	endtask

	task automatic check_addr(input string what, input line_addr_t e, input line_addr_t a);
		if (a !== e)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what, e, a));
	endtask

	task automatic check_kind(input string what, input snoop_t e, input snoop_t a);
		if (a !== e)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what, e, a));
	endtask

	task automatic check_tag(input string what, input mem_tag_u e, input mem_tag_u a);
		if (a.raw !== e.raw)
			stop_run($sformatf("mismatch %s %s: expected %h, actual %h", test_name, what,
				e.raw, a.raw));
	endtask

	task automatic compare_read(input int c, input resp_t r, input line_t l, input trans_t t);
		if (!pending[c])
			stop_run($sformatf("client %0d returned read data with no read outstanding", c));
		check_resp("rdata resp", exp_resp[c], r);
		check_line("rdata line", exp_line[c], l);
		check_trans("rdata trans", exp_trans[c], t);
		pending[c] = 1'b0;
		n_rdata++;
	endtask

	always @(posedge clk) begin : compare
		if (!reset) begin
			if (ic0_rdata_req && ic0_rdata_ack)
				compare_read(0, ic0_rdata_resp, ic0_rdata, ic0_rdata_trans);
			if (dc0_rdata_req && dc0_rdata_ack)
				compare_read(1, dc0_rdata_resp, dc0_rdata, dc0_rdata_trans);
			if (dc0_wdata_done) begin
				if (!wr_done_pend || wr_mem_pend)
					stop_run("dc0 write done came before its memory write");
				check_trans("write done trans", wr_trans, dc0_wdata_trans);
				wr_done_pend = 1'b0;
			end
		end
	end

	// --------------------
	// models
	always @(posedge clk) begin : cache_ack_model
		#1;
		ic0_rdata_ack = coin(2);
		dc0_rdata_ack = coin(2);
	end

	always @(posedge clk) begin : snoop_model
		logic dc_hs;
		dc_hs = dc0_snoop_addr_req && dc0_snoop_addr_ack;
		if (dc_hs) begin
			dc_snp_addr = dc0_snoop_addr;
			if (!pending[0])
				stop_run("dc0 was snooped with no ic0 read outstanding");
			check_addr("dc0 snoop addr", exp_addr[0], dc0_snoop_addr);
			check_kind("dc0 snoop kind", exp_snoop[0], dc0_snoop_snoop);
		end
		if (ic0_snoop_addr_req && ic0_snoop_addr_ack) begin
			if (pending[1]) begin	// dc0 read looking in ic0
				check_addr("ic0 snoop addr", exp_addr[1], ic0_snoop_addr);
				check_kind("ic0 snoop kind", exp_snoop[1], ic0_snoop_snoop);
			end else begin	// writeback invalidate
				ic_snp_addr = ic0_snoop_addr;
				ic_snp_kind = ic0_snoop_snoop;
			end
		end
		#1;
		ic0_snoop_addr_ack  = ic0_snoop_addr_req && coin(3);
		dc0_snoop_addr_ack  = dc0_snoop_addr_req && coin(3);
		ic0_snoop_data_resp = RESP_MEM;
		dc0_snoop_data_resp = (dc_hs && dc_snp_addr[0]) ? DC_HIT_RESP : RESP_MEM;
		dc0_snoop_data      = (dc_hs && dc_snp_addr[0]) ? line_of_dc(dc_snp_addr) : '0;
	end

	always @(posedge clk) begin : mem_read_model
		int       idx;
		logic     taken;
		mem_tag_u tag;
		taken = mem_rdata_req && mem_rdata_ack;
		tag   = mem_raddr_trans;
		if (!reset && mem_raddr_req && mem_raddr_ack) begin
			if (!pending[tag.f.client] || !exp_mem[tag.f.client])
				stop_run("memory read issued for a read that needs none");
			check_addr("mem read addr", exp_addr[tag.f.client], mem_raddr);
			check_trans("mem read trans", exp_trans[tag.f.client], tag.f.trans);
			rd_q_addr.push_back(mem_raddr);
			rd_q_tag.push_back(tag);
		end
		#1;
		mem_raddr_ack = coin(3);
		if (taken)
			mem_rdata_req = 1'b0;
		if (!mem_rdata_req && rd_q_addr.size() > 0 && coin(4)) begin
			idx = int'($unsigned($random(seed)) % rd_q_addr.size());	// any order
			mem_rdata       = line_of_mem(rd_q_addr[idx]);
			mem_rdata_trans = rd_q_tag[idx];
			mem_rdata_req   = 1'b1;
			rd_q_addr.delete(idx);
			rd_q_tag.delete(idx);
		end
	end

	always @(posedge clk) begin : mem_write_model
		int       done_wait;
		mem_tag_u done_tag;
		mem_tag_u exp_tag;
		if (!reset && mem_waddr_req && mem_waddr_ack) begin
			if (!wr_mem_pend)
				stop_run("memory write with no writeback outstanding");
			check_addr("mem write addr", wr_addr, mem_waddr);
			check_line("mem write data", wr_data, mem_wdata);
			exp_tag.f.client = 1'b1;	// dc0
			exp_tag.f.trans  = wr_trans;
			check_tag("mem write tag", exp_tag, mem_waddr_trans);
			wr_mem_pend = 1'b0;
			done_tag    = mem_waddr_trans;
			done_wait   = 1 + int'($unsigned($random(seed)) % 4);
		end
		#1;
		mem_waddr_ack  = coin(3);
		mem_wdata_done = 1'b0;
		if (done_wait > 0) begin
			done_wait--;
			if (done_wait == 0) begin
				mem_wdata_done  = 1'b1;
				mem_wdata_trans = done_tag;
			end
		end
	end

	// --------------------
	// drivers, called 1 ns after a rising edge
	task automatic issue_read(input int c, input rsnoop_t k, input line_addr_t a, input trans_t t);
		logic acc;
		if (c == 0) begin
			ic0_raddr       = a;
			ic0_raddr_snoop = k;
			ic0_raddr_trans = t;
			ic0_raddr_req   = 1'b1;
		end else begin
			dc0_raddr       = a;
			dc0_raddr_snoop = k;
			dc0_raddr_trans = t;
			dc0_raddr_req   = 1'b1;
		end
		acc = 1'b0;
		while (!acc) begin
			@(posedge clk);
			acc = (c == 0) ? ic0_raddr_ack : dc0_raddr_ack;
		end
		if (k != RSNOOP_READ_CANCEL) begin
			exp_mem[c]   = expected_read(c, k, a, exp_resp[c], exp_line[c]);
			exp_snoop[c] = snoop_for_read(k);
			exp_addr[c]  = a;
			exp_trans[c] = t;
			pending[c]   = 1'b1;
		end else
			n_cancels++;	// no data comes back
		n_issued++;
		#1;
		if (c == 0)
			ic0_raddr_req = 1'b0;
		else
			dc0_raddr_req = 1'b0;
	endtask

	task automatic wait_read(input int c);
		wait (!pending[c]);
		@(posedge clk);
		#1;
	endtask

	task automatic issue_write(input line_addr_t a, input line_t d, input trans_t t);
		dc0_waddr       = a;
		dc0_wdata       = d;
		dc0_waddr_trans = t;
		dc0_waddr_req   = 1'b1;
		do @(posedge clk); while (!dc0_waddr_ack);
		wr_addr      = a;
		wr_data      = d;
		wr_trans     = t;
		wr_mem_pend  = 1'b1;
		wr_done_pend = 1'b1;
		#1 dc0_waddr_req = 1'b0;
		wait (!wr_mem_pend && !wr_done_pend);
		do @(posedge clk); while (!dc0_waddr_ack);	// snoop finished too
		check_addr("ic0 invalidate addr", a, ic_snp_addr);
		check_kind("ic0 invalidate kind", SNOOP_READ_INVALID, ic_snp_kind);
		#1;
	endtask

	task automatic run_stream(input int c);
		trans_t     t;
		line_addr_t a;
		t = trans_t'(8 * c);
		for (int i = 0; i < N_RAND; i++) begin
			a = line_addr_t'({$random(seed), $random(seed)}) & ~line_addr_t'(1);	// memory only
			if (i % 5 == 4)
				issue_read(c, RSNOOP_READ_CANCEL, a, t);
			else
				issue_read(c, rsnoop_t'(3'($unsigned($random(seed)) % 3)), a, t);
			t = trans_t'(t + 1);
		end
		wait_read(c);
	endtask

	// --------------------
	initial begin : watchdog
		repeat (400 * N_OPS) @(posedge clk);
		$display("timeout: no result after %0d cycles", 400 * N_OPS);
		$display("Verification failed");
		$fatal(1);
	end

	initial begin : main
		seed = 32'he24d_06dd;
		reset = 1'b1;
		{ic0_raddr, ic0_raddr_req, ic0_raddr_trans, ic0_rdata_ack} = '0;
		{dc0_raddr, dc0_raddr_req, dc0_raddr_trans, dc0_rdata_ack} = '0;
		ic0_raddr_snoop = RSNOOP_READ_LINE;
		dc0_raddr_snoop = RSNOOP_READ_LINE;
		{dc0_waddr, dc0_waddr_req, dc0_waddr_trans, dc0_wdata} = '0;
		{ic0_snoop_addr_ack, dc0_snoop_addr_ack, dc0_snoop_data} = '0;
		ic0_snoop_data_resp = RESP_MEM;
		dc0_snoop_data_resp = RESP_MEM;
		{mem_raddr_ack, mem_rdata, mem_rdata_trans, mem_rdata_req} = '0;
		{mem_waddr_ack, mem_wdata_trans, mem_wdata_done} = '0;
		pending = '{default: 1'b0};
		exp_mem = '{default: 1'b0};
		{wr_mem_pend, wr_done_pend} = 2'b00;
		n_issued  = 0;
		n_cancels = 0;
		n_rdata   = 0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;

		test_name = "ic0_read_mem";
		issue_read(0, RSNOOP_READ_LINE, 42'h0123_4567_a0, 6'h11);
		wait_read(0);
		test_name = "ic0_read_dc0_owned";
		issue_read(0, RSNOOP_READ_LINE_SHARED, 42'h0aa5_5aa5_13, 6'h12);
		wait_read(0);
		test_name = "dc0_inv_shared";
		issue_read(1, RSNOOP_READ_LINE_INV_SHARED, 42'h0777_0000_41, 6'h23);
		wait_read(1);
		test_name = "dc0_write";
		issue_write(42'h0321_fedc_b8, line_of_mem(42'h1234_5678), 6'h2c);

		test_name = "overlap_reads";
		fork
			run_stream(0);
			run_stream(1);
		join

		if (n_rdata != n_issued - n_cancels)
			stop_run($sformatf("%0d reads and %0d cancels gave %0d data returns",
				n_issued - n_cancels, n_cancels, n_rdata));
		else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

/* list.f */
verilog/mi_pkg.sv
verilog/mi_ifs.sv
verilog/snoop_arbiter.sv
verilog/client_read_port.sv
verilog/line_writeback.sv
verilog/mem_read_mux.sv
verilog/mem_interconnect.sv
dv/tb_mem_interconnect.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide by searching the simulation log
verilator --binary --assert -j 0 --top-module tb_mem_interconnect -f list.f \
	-o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Verification failed" sim.log && { cat sim.log; exit 1; }
grep -q "Verification passed" sim.log && echo "PASS" || { cat sim.log; exit 1; }
